//--- sim/cpu_on_board_stim.txt
# W addr data be | R addr rdata err | K code | B code | U byte | I vector (hex)
# Memory rows take LCG data and model values, so their data column is 0
W 00000000 00000000 f
W 00000004 00000000 f
W 00000008 00000000 f
W 00000ffc 00000000 f
W 00000000 00000000 3
W 00000004 00000000 c
W 00000008 00000000 5
W 00000ffc 00000000 a
R 00000000 00000000 0
R 00000004 00000000 0
R 00000008 00000000 0
R 00000ffc 00000000 0
R 00001010 00000000 1
R 00002000 00000000 1
W 0000100c 00000003 f
R 0000100c 00000000 0
I 0
K 1c
I 1
R 00001008 0000021c 0
R 00001008 0000001c 0
K f0
K 1c
I 0
R 00001008 0000031c 0
B 2a
R 00001008 0000011c 0
W 00001000 00000041 1
W 00001000 00000042 1
U 41
U 42
K 29
I 1
I 2
I 0
R 0000100c 00000000 0
R 00001004 00000000 0

//--- tb.f
logic/soc_pkg.sv
logic/board_bus_decoder.sv
logic/onchip_mem.sv
logic/ps2_receiver.sv
logic/console_tx.sv
logic/irq_ctrl.sv
logic/cpu_on_board.sv
sim/bus_chk.sv
sim/tb_cpu_on_board.sv

//--- sim/tb_cpu_on_board.sv
module tb_cpu_on_board;
    timeunit 1ns;
    timeprecision 1ps;

    import soc_pkg::*;

    localparam int bus_timeout  = 6000;
    localparam int uart_timeout = 30 * console_div;
    localparam int irq_timeout  = 200;
    localparam int ps2_half     = 40;

    logic        CLOCK_50 = 1'b0;
    logic        KEY0;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        req;
    bus_req_t    breq;
    logic        ack;
    bus_rsp_t    brsp;
    logic [3:0]  irq_vector;
    logic        irq_ack;
    logic        uart_tx;

    logic [31:0] rand_state = 32'h439b;
    logic [31:0] mem_model [mem_words];
    logic [7:0]  byte_q [$];

    // Console line decoder state
    logic        mon_busy;
    int          mon_cnt;
    int          mon_bit;
    logic [7:0]  mon_data;

    cpu_on_board cpu_on_board_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .req        (req),
        .breq       (breq),
        .ack        (ack),
        .brsp       (brsp),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack),
        .uart_tx    (uart_tx)
    );

    bind cpu_on_board bus_chk bus_chk_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .ack      (ack),
        .breq     (breq)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("FAIL at %0d ns: %s is %h, expected %h",
                                $time, name, got, expected));
        end
    endtask

    // Every task starts and ends 1 ns after a rising edge
    task automatic idle_clocks(input int n);
        repeat (n) begin
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             output bus_rsp_t rsp);
        int waited;
        breq = '{write: write, addr: addr, wdata: wdata, be: be};
        req = 1'b1;
        waited = 0;
        while (!ack) begin
            if (waited == bus_timeout) begin
                abort_run($sformatf("no ack for the bus access to %h", addr));
            end
            idle_clocks(1);
            waited++;
        end
        rsp = brsp;
        req = 1'b0;
        waited = 0;
        while (ack) begin
            if (waited == bus_timeout) begin
                abort_run("ack stayed high after req was dropped");
            end
            idle_clocks(1);
            waited++;
        end
    endtask

    // Start, data LSB first, parity, stop
    task automatic send_ps2_frame(input logic [7:0] code, input logic good_parity);
        logic [10:0] bits;
        bits = {1'b1, good_parity ? ~^code : ^code, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = bits[i];
            idle_clocks(ps2_half);
            ps2_clk = 1'b0;
            idle_clocks(ps2_half);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic take_vector(input logic [3:0] expected);
        int waited;
        waited = 0;
        while (irq_vector !== expected && waited < irq_timeout) begin
            idle_clocks(1);
            waited++;
        end
        check_value("irq_vector", irq_vector, expected);
        irq_ack = 1'b1;
        idle_clocks(1);
        irq_ack = 1'b0;
        // Vector clears, then the next pending one shows
        idle_clocks(2);
    endtask

    task automatic expect_console(input logic [7:0] expected);
        int waited;
        waited = 0;
        while (byte_q.size() == 0) begin
            if (waited == uart_timeout) begin
                abort_run("no byte arrived on the console line");
            end
            idle_clocks(1);
            waited++;
        end
        check_value("uart_tx byte", byte_q.pop_front(), expected);
    endtask

    task automatic run_command(input string cmd, input int fd);
        int          n;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        bus_rsp_t    rsp;
        case (cmd)
            "W": begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                if (n != 3) begin
                    abort_run("a W line in the stim file is incomplete");
                end
                // Memory gets random data, tracked by the model
                if (a < io_base) begin
                    d = next_rand();
                    for (int i = 0; i < 4; i++) begin
                        if (e[i]) begin
                            mem_model[a[mem_aw+1:2]][8*i +: 8] = d[8*i +: 8];
                        end
                    end
                end
                bus_cycle(1'b1, a, d, e[3:0], rsp);
            end
            "R": begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                if (n != 3) begin
                    abort_run("an R line in the stim file is incomplete");
                end
                if (a < io_base) begin
                    d = mem_model[a[mem_aw+1:2]];
                end
                bus_cycle(1'b0, a, 32'h0, 4'h0, rsp);
                check_value("brsp.rdata", rsp.rdata, d);
                check_value("brsp.err", rsp.err, e[0]);
            end
            "K", "B", "U", "I": begin
                n = $fscanf(fd, "%h", d);
                if (n != 1) begin
                    abort_run($sformatf("a %s line in the stim file has no value", cmd));
                end
                if (cmd == "K") begin
                    send_ps2_frame(d[7:0], 1'b1);
                end else if (cmd == "B") begin
                    send_ps2_frame(d[7:0], 1'b0);
                end else if (cmd == "U") begin
                    expect_console(d[7:0]);
                end else begin
                    take_vector(d[3:0]);
                end
            end
            default: abort_run($sformatf("unknown command %s in the stim file", cmd));
        endcase
    endtask

    // Samples the console line at mid-bit
    always @(posedge CLOCK_50) begin
        if (!KEY0) begin
            mon_busy = 1'b0;
        end else if (!mon_busy) begin
            if (!uart_tx) begin
                mon_busy = 1'b1;
                mon_bit  = 0;
                mon_cnt  = console_div / 2 - 1;
            end
        end else if (mon_cnt != 0) begin
            mon_cnt--;
        end else begin
            mon_cnt = console_div - 1;
            if (mon_bit == 0) begin
                if (uart_tx) begin
                    abort_run("console start bit did not stay low");
                end
            end else if (mon_bit < 9) begin
                mon_data[mon_bit-1] = uart_tx;
            end else begin
                if (!uart_tx) begin
                    abort_run("console stop bit is low");
                end
                byte_q.push_back(mon_data);
                mon_busy = 1'b0;
            end
            mon_bit++;
        end
    end

    // Handshake assertion failures end the run
    always @(posedge CLOCK_50) begin
        if (cpu_on_board_i.bus_chk_i.fail_cnt != 0) begin
            abort_run("a bus handshake assertion failed");
        end
    end

    initial begin
        int    fd;
        int    n;
        string cmd;
        string skip;
        KEY0    = 1'b0;
        req     = 1'b0;
        breq    = '0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        irq_ack = 1'b0;
        idle_clocks(8);
        KEY0 = 1'b1;
        idle_clocks(2);

        fd = $fopen("sim/cpu_on_board_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/cpu_on_board_stim.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                break;
            end
            if (cmd[0] == "#") begin
                n = $fgets(skip, fd);
            end else begin
                run_command(cmd, fd);
                idle_clocks(next_rand() % 4);
            end
        end
        $fclose(fd);

        if (cpu_on_board_i.bus_chk_i.fail_cnt != 0) begin
            abort_run("a bus handshake assertion failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- sim/bus_chk.sv
module bus_chk (
    input logic              CLOCK_50,
    input logic              KEY0,
    input logic              req,
    input logic              ack,
    input soc_pkg::bus_req_t breq
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions so far
    int fail_cnt = 0;

    // Ack only answers a live request
    ack_needs_req: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        $rose(ack) |-> $past(req)
    ) else begin
        $error("ack rose while req was low");
        fail_cnt++;
    end

    // Master keeps req up until ack arrives
    req_held: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        $fell(req) |-> ack
    ) else begin
        $error("req dropped before ack");
        fail_cnt++;
    end

    breq_stable: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        req && $past(req) |-> $stable(breq)
    ) else begin
        $error("breq changed while req was high");
        fail_cnt++;
    end

endmodule

//--- logic/cpu_on_board.sv
module cpu_on_board (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    input  logic              req,
    input  soc_pkg::bus_req_t breq,
    output logic              ack,
    output soc_pkg::bus_rsp_t brsp,
    output logic [3:0]        irq_vector,
    input  logic              irq_ack,
    output logic              uart_tx
);
    import soc_pkg::*;

    logic              mem_en;
    logic              mem_we;
    logic [mem_aw-1:0] mem_index;
    logic [31:0]       mem_wdata;
    logic [3:0]        mem_be;
    logic [31:0]       mem_rdata;
    logic              tx_load;
    logic [7:0]        tx_byte;
    logic              tx_busy;
    logic              tx_done;
    key_event_t        key;
    logic              key_consume;
    logic              key_make;
    logic [1:0]        irq_pending;

    board_bus_decoder board_bus_decoder_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .req         (req),
        .breq        (breq),
        .ack         (ack),
        .brsp        (brsp),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_index   (mem_index),
        .mem_wdata   (mem_wdata),
        .mem_be      (mem_be),
        .mem_rdata   (mem_rdata),
        .tx_load     (tx_load),
        .tx_byte     (tx_byte),
        .tx_busy     (tx_busy),
        .key         (key),
        .key_consume (key_consume),
        .irq_pending (irq_pending)
    );

    onchip_mem onchip_mem_i (
        .CLOCK_50 (CLOCK_50),
        .en       (mem_en),
        .we       (mem_we),
        .index    (mem_index),
        .wdata    (mem_wdata),
        .be       (mem_be),
        .rdata    (mem_rdata)
    );

    ps2_receiver ps2_receiver_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .key      (key),
        .consume  (key_consume),
        .key_make (key_make)
    );

    // Serial console in place of the JTAG UART
    console_tx console_tx_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .load     (tx_load),
        .byte_in  (tx_byte),
        .busy     (tx_busy),
        .tx_done  (tx_done),
        .uart_tx  (uart_tx)
    );

    irq_ctrl irq_ctrl_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_make   (key_make),
        .tx_done    (tx_done),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector),
        .pending    (irq_pending)
    );

endmodule

//--- logic/irq_ctrl.sv
module irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_make,
    input  logic       tx_done,
    input  logic       irq_ack,
    output logic [3:0] irq_vector,
    output logic [1:0] pending
);
    import soc_pkg::*;

    logic       ack_key;
    logic       ack_con;
    logic [1:0] pending_nxt;
    logic [3:0] vec_nxt;

    // Acknowledge only clears the source on display
    assign ack_key = irq_ack && irq_vector == vec_key;
    assign ack_con = irq_ack && irq_vector == vec_console;

    assign pending_nxt[0] = key_make || (pending[0] && !ack_key);
    assign pending_nxt[1] = tx_done || (pending[1] && !ack_con);

    // Key wins over console
    always_comb begin
        if (ack_key || ack_con) begin
            vec_nxt = vec_none;
        end else if (pending_nxt[0]) begin
            vec_nxt = vec_key;
        end else if (pending_nxt[1]) begin
            vec_nxt = vec_console;
        end else begin
            vec_nxt = vec_none;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending    <= '0;
            irq_vector <= vec_none;
        end else begin
            pending    <= pending_nxt;
            irq_vector <= vec_nxt;
        end
    end

endmodule

//--- logic/console_tx.sv
module console_tx (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       load,
    input  logic [7:0] byte_in,
    output logic       busy,
    output logic       tx_done,
    output logic       uart_tx
);
    import soc_pkg::*;

    logic [9:0] shift;
    logic [3:0] bit_cnt;
    logic       baud_end;
    logic [$clog2(console_div)-1:0] baud_cnt;

    assign baud_end = baud_cnt == console_div - 1;

    // Line idles high through the all-ones shifter
    assign uart_tx = shift[0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            shift    <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            busy     <= 1'b0;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!busy) begin
                if (load) begin
                    // Stop, data, start
                    shift    <= {1'b1, byte_in, 1'b0};
                    busy     <= 1'b1;
                    bit_cnt  <= '0;
                    baud_cnt <= '0;
                end
            end else if (baud_end) begin
                baud_cnt <= '0;
                shift    <= {1'b1, shift[9:1]};
                // Tenth bit period is the stop bit
                if (bit_cnt == 4'd9) begin
                    busy    <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/ps2_receiver.sv
module ps2_receiver (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output soc_pkg::key_event_t key,
    input  logic                consume,
    output logic                key_make
);
    import soc_pkg::*;

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;
    logic [9:0]  shift;
    logic [3:0]  bit_cnt;
    logic [10:0] frame;
    logic        frame_ok;
    logic        frame_vld;
    logic [7:0]  frame_code;
    logic        brk;
    logic [$clog2(ps2_timeout+1)-1:0] idle_cnt;

    assign clk_fall = clk_prev && !clk_sync[1];

    // Start, 8 data LSB first, odd parity, stop
    assign frame    = {dat_sync[1], shift};
    assign frame_ok = !frame[0] && frame[10] && ^frame[9:1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Bit counter and idle timeout
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt   <= '0;
            idle_cnt  <= '0;
            frame_vld <= 1'b0;
        end else begin
            frame_vld <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt   <= '0;
                    frame_vld <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != '0) begin
                if (idle_cnt == ps2_timeout - 1) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            if (bit_cnt == 4'd10) begin
                frame_code <= frame[8:1];
            end else begin
                shift <= {dat_sync[1], shift[9:1]};
            end
        end
    end

    // Make/break decode
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key      <= '0;
            key_make <= 1'b0;
            brk      <= 1'b0;
        end else begin
            key_make <= 1'b0;
            if (consume) begin
                key.valid <= 1'b0;
            end
            // A new event beats a consume in the same clock
            if (frame_vld) begin
                if (frame_code == ps2_break_code) begin
                    brk <= 1'b1;
                end else begin
                    key.valid    <= 1'b1;
                    key.released <= brk;
                    key.code     <= frame_code;
                    key_make     <= !brk;
                    brk          <= 1'b0;
                end
            end
        end
    end

endmodule

//--- logic/onchip_mem.sv
module onchip_mem (
    input  logic                       CLOCK_50,
    input  logic                       en,
    input  logic                       we,
    input  logic [soc_pkg::mem_aw-1:0] index,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 be,
    output logic [31:0]                rdata
);
    import soc_pkg::*;

    logic [31:0] mem [mem_words];

    // Byte lanes written independently
    always_ff @(posedge CLOCK_50) begin
        if (en && we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[index][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read, old word on a write cycle
    always_ff @(posedge CLOCK_50) begin
        if (en) begin
            rdata <= mem[index];
        end
    end

endmodule

//--- logic/board_bus_decoder.sv
module board_bus_decoder (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic                       req,
    input  soc_pkg::bus_req_t          breq,
    output logic                       ack,
    output soc_pkg::bus_rsp_t          brsp,
    output logic                       mem_en,
    output logic                       mem_we,
    output logic [soc_pkg::mem_aw-1:0] mem_index,
    output logic [31:0]                mem_wdata,
    output logic [3:0]                 mem_be,
    input  logic [31:0]                mem_rdata,
    output logic                       tx_load,
    output logic [7:0]                 tx_byte,
    input  logic                       tx_busy,
    input  soc_pkg::key_event_t        key,
    output logic                       key_consume,
    input  logic [1:0]                 irq_pending
);
    import soc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_access,
        st_wait_busy,
        st_respond,
        st_wait_low
    } state_t;

    state_t    state;
    bus_addr_u addr_v;
    logic      sel_mem;
    logic      sel_io;
    logic      sel_con_data;
    logic      sel_con_stat;
    logic      sel_key;
    logic      sel_irq;
    logic      con_write;
    bus_rsp_t  io_rsp;
    bus_rsp_t  rsp_q;

    assign addr_v  = breq.addr;
    assign sel_mem = addr_v.mem.region == mem_base[31:io_sel_w];
    assign sel_io  = addr_v.io.region == io_base[31:io_sel_w];

    assign sel_con_data = sel_io && addr_v.io.sel == reg_console_data[io_sel_w-1:0];
    assign sel_con_stat = sel_io && addr_v.io.sel == reg_console_stat[io_sel_w-1:0];
    assign sel_key      = sel_io && addr_v.io.sel == reg_key[io_sel_w-1:0];
    assign sel_irq      = sel_io && addr_v.io.sel == reg_irq_stat[io_sel_w-1:0];
    assign con_write    = sel_con_data && breq.write;

    // Side effects fire once, only when leaving access or wait_busy
    assign mem_en      = state == st_access && sel_mem;
    assign mem_we      = breq.write;
    assign mem_index   = addr_v.mem.index;
    assign mem_wdata   = breq.wdata;
    assign mem_be      = breq.be;
    assign tx_load     = (state == st_access || state == st_wait_busy) && con_write && !tx_busy;
    assign tx_byte     = breq.wdata[7:0];
    assign key_consume = state == st_access && sel_key && !breq.write;

    // Register reads; memory data is merged in later
    always_comb begin
        io_rsp = '0;
        if (!sel_mem) begin
            if (!(sel_con_data || sel_con_stat || sel_key || sel_irq)) begin
                io_rsp.err = 1'b1;
            end else if (!breq.write) begin
                if (sel_key) begin
                    io_rsp.rdata = {22'b0, key};
                end else if (sel_irq) begin
                    io_rsp.rdata = {30'b0, irq_pending};
                end else if (sel_con_stat) begin
                    io_rsp.rdata = {31'b0, tx_busy};
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    ack <= 1'b0;
                    if (req && !ack) begin
                        state <= st_access;
                    end
                end
                st_access: begin
                    if (con_write && tx_busy) begin
                        state <= st_wait_busy;
                    end else begin
                        state <= st_respond;
                    end
                end
                st_wait_busy: begin
                    if (!tx_busy) begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    ack   <= 1'b1;
                    state <= st_wait_low;
                end
                st_wait_low: begin
                    // ack drops in idle on the next clock
                    if (!req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Key snapshot taken in the same clock as the consume
    always_ff @(posedge CLOCK_50) begin
        if (state == st_access) begin
            rsp_q <= io_rsp;
        end else if (state == st_respond && sel_mem && !breq.write) begin
            rsp_q.rdata <= mem_rdata;
        end
    end

    assign brsp = rsp_q;

endmodule

//--- logic/soc_pkg.sv
package soc_pkg;

    // Memory map
    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);
    localparam int io_sel_w  = mem_aw + 2;
    localparam int region_w  = 32 - io_sel_w;

    localparam logic [31:0] mem_base = 32'h0000_0000;
    localparam logic [31:0] io_base  = 32'h0000_1000;

    // I/O register offsets inside the I/O region
    localparam logic [31:0] reg_console_data = 32'h0000_0000;
    localparam logic [31:0] reg_console_stat = 32'h0000_0004;
    localparam logic [31:0] reg_key          = 32'h0000_0008;
    localparam logic [31:0] reg_irq_stat     = 32'h0000_000C;

    // 115200 baud from 50 MHz
    localparam int console_div = 434;

    // PS/2 idle clocks before a partial frame is thrown away
    localparam int ps2_timeout = 5000;
    localparam logic [7:0] ps2_break_code = 8'hF0;

    // Interrupt vectors
    localparam logic [3:0] vec_none    = 4'd0;
    localparam logic [3:0] vec_key     = 4'd1;
    localparam logic [3:0] vec_console = 4'd2;

    // Held stable by the master while req is high
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } bus_rsp_t;

    typedef struct packed {
        logic [region_w-1:0] region;
        logic [mem_aw-1:0]   index;
        logic [1:0]          offset;
    } mem_addr_t;

    typedef struct packed {
        logic [region_w-1:0] region;
        logic [io_sel_w-1:0] sel;
    } io_addr_t;

    // Same address word, seen as memory or as I/O
    typedef union packed {
        mem_addr_t mem;
        io_addr_t  io;
    } bus_addr_u;

    typedef struct packed {
        logic       valid;
        logic       released;
        logic [7:0] code;
    } key_event_t;

endpackage
